//--- hdl/p_hit_pkg.sv
`default_nettype none

package p_hit_pkg;

    localparam int D_BITS     = 32;
    localparam int Q_BITS     = 16;
    localparam int FIFO_DEPTH = 16;
    // quotient bits produced by the restoring divider
    localparam int DIV_BITS   = D_BITS + Q_BITS;

    typedef logic signed [D_BITS-1:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t normal;
        vec3_t v0;
        vec3_t origin;
        vec3_t dir;
    } hit_query_t;

    typedef struct packed {
        fixed_t t;
        vec3_t  origin;
        vec3_t  dir;
    } t_ray_t;

    // Q16.16 product, full width then back to one word
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [2*D_BITS-1:0] prod;
        prod = a * b;
        prod = prod >>> Q_BITS;
        return prod[D_BITS-1:0];
    endfunction

    // wrapping sum of the three axis products
    function automatic fixed_t fx_dot(input vec3_t a, input vec3_t b);
        return fx_mul(a.x, b.x) + fx_mul(a.y, b.y) + fx_mul(a.z, b.z);
    endfunction

endpackage

`default_nettype wire

//--- hdl/fifo_array.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_array #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 16
) (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          wr_en,
    input  wire T                        din,
    output logic                         full,
    input  wire                          rd_en,
    output T                             dout,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    T mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     push;
    logic                     pop;

    // writes while full are dropped
    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;
    assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty = (count == '0);

    // show-ahead head entry
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/hit_distance.sv
`timescale 1ns/1ns
`default_nettype none

module hit_distance (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire p_hit_pkg::hit_query_t  in_query,
    input  wire                         in_wr_en,
    output logic                        in_full,
    output p_hit_pkg::t_ray_t           out_ray,
    input  wire                         out_rd_en,
    output logic                        out_empty
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DOT,
        S_DIV,
        S_PUSH
    } state_t;

    state_t                                  state;
    logic [$clog2(p_hit_pkg::DIV_BITS)-1:0]  step;

    p_hit_pkg::hit_query_t                   q_head;
    logic                                    q_empty;
    logic                                    q_rd_en;
    p_hit_pkg::hit_query_t                   query;

    p_hit_pkg::t_ray_t                       res_ray;
    logic                                    res_full;
    logic                                    res_wr_en;

    p_hit_pkg::vec3_t                        v0_rel;
    p_hit_pkg::fixed_t                       num;
    p_hit_pkg::fixed_t                       den;
    logic [p_hit_pkg::D_BITS-1:0]            num_mag;
    logic [p_hit_pkg::D_BITS-1:0]            den_mag;

    // dividend leaves at the top, quotient bits enter at the bottom
    logic [p_hit_pkg::DIV_BITS-1:0]          dvd_q;
    logic [p_hit_pkg::D_BITS-1:0]            divisor;
    logic [p_hit_pkg::D_BITS-1:0]            rem;
    logic [p_hit_pkg::D_BITS:0]              rem_shift;
    logic [p_hit_pkg::D_BITS:0]              rem_diff;
    logic                                    q_bit;
    logic                                    neg;
    p_hit_pkg::fixed_t                       t_val;

    fifo_array #(
        .T        (p_hit_pkg::hit_query_t),
        .DEPTH    (p_hit_pkg::FIFO_DEPTH)
    ) query_fifo (
        .clock    (clock),
        .arst_n   (arst_n),
        .wr_en    (in_wr_en),
        .din      (in_query),
        .full     (in_full),
        .rd_en    (q_rd_en),
        .dout     (q_head),
        .empty    (q_empty),
        .count    ()
    );

    fifo_array #(
        .T        (p_hit_pkg::t_ray_t),
        .DEPTH    (p_hit_pkg::FIFO_DEPTH)
    ) ray_fifo (
        .clock    (clock),
        .arst_n   (arst_n),
        .wr_en    (res_wr_en),
        .din      (res_ray),
        .full     (res_full),
        .rd_en    (out_rd_en),
        .dout     (out_ray),
        .empty    (out_empty),
        .count    ()
    );

    assign q_rd_en = (state == S_IDLE) && !q_empty;

    always_comb begin
        v0_rel.x = query.v0.x - query.origin.x;
        v0_rel.y = query.v0.y - query.origin.y;
        v0_rel.z = query.v0.z - query.origin.z;
        num      = p_hit_pkg::fx_dot(query.normal, v0_rel);
        den      = p_hit_pkg::fx_dot(query.normal, query.dir);
        num_mag  = num[p_hit_pkg::D_BITS-1] ? -num : num;
        den_mag  = den[p_hit_pkg::D_BITS-1] ? -den : den;

        // one restoring step
        rem_shift = {rem, dvd_q[p_hit_pkg::DIV_BITS-1]};
        rem_diff  = rem_shift - {1'b0, divisor};
        q_bit     = (rem_shift >= {1'b0, divisor});

        // sign goes back on after the magnitude divide
        t_val = neg ? -dvd_q[p_hit_pkg::D_BITS-1:0] : dvd_q[p_hit_pkg::D_BITS-1:0];

        res_ray.t      = t_val;
        res_ray.origin = query.origin;
        res_ray.dir    = query.dir;
        res_wr_en      = (state == S_PUSH) && !res_full;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!q_empty) begin
                        state <= S_DOT;
                    end
                end
                S_DOT: begin
                    step  <= '0;
                    // zero denominator skips the divider
                    state <= (den == '0) ? S_PUSH : S_DIV;
                end
                S_DIV: begin
                    step <= step + 1'b1;
                    if (step == ($clog2(p_hit_pkg::DIV_BITS))'(p_hit_pkg::DIV_BITS - 1)) begin
                        state <= S_PUSH;
                    end
                end
                S_PUSH: begin
                    // hold until the result FIFO has room
                    if (!res_full) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (q_rd_en) begin
            query <= q_head;
        end
        if (state == S_DOT) begin
            dvd_q   <= (den == '0) ? '0 : {num_mag, {p_hit_pkg::Q_BITS{1'b0}}};
            divisor <= den_mag;
            rem     <= '0;
            neg     <= num[p_hit_pkg::D_BITS-1] ^ den[p_hit_pkg::D_BITS-1];
        end else if (state == S_DIV) begin
            dvd_q <= {dvd_q[p_hit_pkg::DIV_BITS-2:0], q_bit};
            rem   <= q_bit ? rem_diff[p_hit_pkg::D_BITS-1:0] : rem_shift[p_hit_pkg::D_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/p_hit_point.sv
`timescale 1ns/1ns
`default_nettype none

module p_hit_point (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire p_hit_pkg::t_ray_t   in_ray,
    input  wire                      in_empty,
    output logic                     in_rd_en,
    output p_hit_pkg::vec3_t         out_p_hit,
    input  wire                      out_rd_en,
    output logic                     out_empty
);

    logic                                         s1_valid;
    p_hit_pkg::vec3_t                             s1_prod;
    p_hit_pkg::vec3_t                             s1_origin;
    logic                                         s2_valid;
    p_hit_pkg::vec3_t                             s2_sum;
    logic [$clog2(p_hit_pkg::FIFO_DEPTH+1)-1:0]   o_count;
    // output entries plus items still in the pipe
    logic [$clog2(p_hit_pkg::FIFO_DEPTH+1):0]     credit_used;

    assign credit_used = o_count + s1_valid + s2_valid;
    assign in_rd_en    = !in_empty && (credit_used < p_hit_pkg::FIFO_DEPTH);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_rd_en;
            s2_valid <= s1_valid;
        end
    end

    // stage one, t times direction
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            s1_prod.x <= p_hit_pkg::fx_mul(in_ray.t, in_ray.dir.x);
            s1_prod.y <= p_hit_pkg::fx_mul(in_ray.t, in_ray.dir.y);
            s1_prod.z <= p_hit_pkg::fx_mul(in_ray.t, in_ray.dir.z);
            s1_origin <= in_ray.origin;
        end
    end

    // stage two, add the origin
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            s2_sum.x <= s1_origin.x + s1_prod.x;
            s2_sum.y <= s1_origin.y + s1_prod.y;
            s2_sum.z <= s1_origin.z + s1_prod.z;
        end
    end

    fifo_array #(
        .T        (p_hit_pkg::vec3_t),
        .DEPTH    (p_hit_pkg::FIFO_DEPTH)
    ) point_fifo (
        .clock    (clock),
        .arst_n   (arst_n),
        .wr_en    (s2_valid),
        .din      (s2_sum),
        .full     (),
        .rd_en    (out_rd_en),
        .dout     (out_p_hit),
        .empty    (out_empty),
        .count    (o_count)
    );

endmodule

`default_nettype wire

//--- hdl/p_hit.sv
`timescale 1ns/1ns
`default_nettype none

module p_hit (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire p_hit_pkg::hit_query_t  in_query,
    input  wire                         in_wr_en,
    output logic                        in_full,
    output p_hit_pkg::vec3_t            out_p_hit,
    input  wire                         out_rd_en,
    output logic                        out_empty
);

    // between the divider stage and the multiply-add stage
    p_hit_pkg::t_ray_t   mid_ray;
    logic                mid_empty;
    logic                mid_rd_en;

    hit_distance u_hit_distance (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_query     (in_query),
        .in_wr_en     (in_wr_en),
        .in_full      (in_full),
        .out_ray      (mid_ray),
        .out_rd_en    (mid_rd_en),
        .out_empty    (mid_empty)
    );

    p_hit_point u_p_hit_point (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_ray       (mid_ray),
        .in_empty     (mid_empty),
        .in_rd_en     (mid_rd_en),
        .out_p_hit    (out_p_hit),
        .out_rd_en    (out_rd_en),
        .out_empty    (out_empty)
    );

endmodule

`default_nettype wire

//--- test/p_hit_checker.sv
`timescale 1ns/1ns
`default_nettype none

module p_hit_checker (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire p_hit_pkg::hit_query_t  in_query,
    input  wire                         in_wr_en,
    input  wire                         in_full,
    input  wire [95:0]                  in_name,
    input  wire p_hit_pkg::vec3_t       in_exp,
    input  wire                         in_exp_valid,
    input  wire p_hit_pkg::vec3_t       out_p_hit,
    input  wire                         out_rd_en,
    input  wire                         out_empty,
    output int                          n_done,
    output int                          n_pass,
    output int                          n_errors
);

    // pending queries in write order
    logic [95:0]       name_q [$];
    p_hit_pkg::vec3_t  exp_q  [$];

    function automatic p_hit_pkg::fixed_t fixed_mul(input p_hit_pkg::fixed_t a,
                                                    input p_hit_pkg::fixed_t b);
        logic signed [63:0] wide;
        wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        wide = wide >>> p_hit_pkg::Q_BITS;
        return wide[31:0];
    endfunction

    // p = o + t*d with t = n.(v0 - o) / n.d
    function automatic p_hit_pkg::vec3_t expected_point(input p_hit_pkg::hit_query_t q);
        p_hit_pkg::fixed_t  num;
        p_hit_pkg::fixed_t  den;
        logic signed [63:0] wide_num;
        logic signed [63:0] quo;
        p_hit_pkg::fixed_t  t;
        p_hit_pkg::vec3_t   p;
        num = fixed_mul(q.normal.x, q.v0.x - q.origin.x)
            + fixed_mul(q.normal.y, q.v0.y - q.origin.y)
            + fixed_mul(q.normal.z, q.v0.z - q.origin.z);
        den = fixed_mul(q.normal.x, q.dir.x)
            + fixed_mul(q.normal.y, q.dir.y)
            + fixed_mul(q.normal.z, q.dir.z);
        wide_num = num;
        wide_num = wide_num <<< p_hit_pkg::Q_BITS;
        // signed divide truncates toward zero
        quo = (den == 0) ? 64'sd0 : wide_num / 64'(den);
        t   = quo[31:0];
        p.x = q.origin.x + fixed_mul(t, q.dir.x);
        p.y = q.origin.y + fixed_mul(t, q.dir.y);
        p.z = q.origin.z + fixed_mul(t, q.dir.z);
        return p;
    endfunction

    always @(posedge clock) begin
        p_hit_pkg::vec3_t model;
        p_hit_pkg::vec3_t exp_p;
        logic [95:0]      test_name;
        if (!arst_n) begin
            n_done   = 0;
            n_pass   = 0;
            n_errors = 0;
            name_q.delete();
            exp_q.delete();
        end else begin
            if (in_wr_en && !in_full) begin
                model = expected_point(in_query);
                if (in_exp_valid && model !== in_exp) begin
                    $display("table value for %0s does not follow the arithmetic rules", in_name);
                    n_errors++;
                end
                name_q.push_back(in_name);
                exp_q.push_back(model);
            end
            if (out_rd_en && !out_empty) begin
                if (name_q.size() == 0) begin
                    $display("a result came out with no query pending: (%h, %h, %h)",
                             out_p_hit.x, out_p_hit.y, out_p_hit.z);
                    n_errors++;
                end else begin
                    test_name = name_q.pop_front();
                    exp_p     = exp_q.pop_front();
                    n_done++;
                    if (out_p_hit === exp_p) begin
                        n_pass++;
                        $display("ok    %0d %0s (%h, %h, %h)", n_done, test_name,
                                 out_p_hit.x, out_p_hit.y, out_p_hit.z);
                    end else begin
                        n_errors++;
                        $display("ERROR %0s expected (%h, %h, %h) actual (%h, %h, %h)",
                                 test_name, exp_p.x, exp_p.y, exp_p.z,
                                 out_p_hit.x, out_p_hit.y, out_p_hit.z);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/p_hit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module p_hit_tb;

    localparam int N_DIRECTED = 7;
    localparam int N_RANDOM   = 24;
    localparam int N_TOTAL    = N_DIRECTED + N_RANDOM;
    localparam int MAX_CYCLES = N_TOTAL * 60 + 500;

    logic                   clock;
    logic                   arst_n;
    p_hit_pkg::hit_query_t  in_query;
    logic                   in_wr_en;
    logic                   in_full;
    p_hit_pkg::vec3_t       out_p_hit;
    logic                   out_rd_en;
    logic                   out_empty;

    // travels alongside each write
    logic [95:0]            cur_name;
    p_hit_pkg::vec3_t       cur_exp;
    logic                   cur_exp_valid;

    int                     n_done;
    int                     n_pass;
    int                     n_errors;
    int                     tb_errors;
    int                     cycles;
    int                     seed;
    logic                   saw_full;

    logic [95:0]            tab_name  [N_DIRECTED];
    p_hit_pkg::hit_query_t  tab_query [N_DIRECTED];
    p_hit_pkg::vec3_t       tab_exp   [N_DIRECTED];

    p_hit UUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_query   (in_query),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .out_p_hit  (out_p_hit),
        .out_rd_en  (out_rd_en),
        .out_empty  (out_empty)
    );

    p_hit_checker check_unit (
        .clock         (clock),
        .arst_n        (arst_n),
        .in_query      (in_query),
        .in_wr_en      (in_wr_en),
        .in_full       (in_full),
        .in_name       (cur_name),
        .in_exp        (cur_exp),
        .in_exp_valid  (cur_exp_valid),
        .out_p_hit     (out_p_hit),
        .out_rd_en     (out_rd_en),
        .out_empty     (out_empty),
        .n_done        (n_done),
        .n_pass        (n_pass),
        .n_errors      (n_errors)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycles, n_done, N_TOTAL);
            $display("sim failed");
            $finish;
        end
    end

    function automatic p_hit_pkg::vec3_t make_vec(input real x, input real y, input real z);
        p_hit_pkg::vec3_t v;
        v.x = $rtoi(x * 65536.0);
        v.y = $rtoi(y * 65536.0);
        v.z = $rtoi(z * 65536.0);
        return v;
    endfunction

    // within +-64.0
    function automatic p_hit_pkg::fixed_t rand_fixed();
        return $random(seed) % 32'sh0040_0000;
    endfunction

    function automatic p_hit_pkg::hit_query_t rand_query();
        p_hit_pkg::hit_query_t q;
        q.normal.x = rand_fixed();
        q.normal.y = rand_fixed();
        q.normal.z = rand_fixed();
        q.v0.x     = rand_fixed();
        q.v0.y     = rand_fixed();
        q.v0.z     = rand_fixed();
        q.origin.x = rand_fixed();
        q.origin.y = rand_fixed();
        q.origin.z = rand_fixed();
        q.dir.x    = rand_fixed();
        q.dir.y    = rand_fixed();
        q.dir.z    = rand_fixed();
        return q;
    endfunction

    task automatic set_entry(input int idx, input logic [95:0] name,
                             input p_hit_pkg::vec3_t n, v0, o, d, p);
        tab_name[idx]         = name;
        tab_query[idx].normal = n;
        tab_query[idx].v0     = v0;
        tab_query[idx].origin = o;
        tab_query[idx].dir    = d;
        tab_exp[idx]          = p;
    endtask

    // expected points worked out by hand
    task automatic fill_table();
        set_entry(0, "axis_z", make_vec(0, 0, 1), make_vec(0, 0, 5), make_vec(0, 0, 0),
                  make_vec(1, 2, 1), make_vec(5, 10, 5));
        set_entry(1, "axis_x", make_vec(1, 0, 0), make_vec(3, 0, 0), make_vec(1, 1, 1),
                  make_vec(2, 0, 0), make_vec(3, 1, 1));
        set_entry(2, "neg_t", make_vec(0, 1, 0), make_vec(0, -2, 0), make_vec(0, 4, 0),
                  make_vec(1, 1, 0), make_vec(-6, -2, 0));
        // t = 1/3 truncates to 0x5555
        set_entry(3, "trunc_pos", make_vec(0, 0, 1), make_vec(0, 0, 1), make_vec(0, 0, 0),
                  make_vec(0, 0, 3), make_vec(0, 0, 65535.0 / 65536.0));
        set_entry(4, "trunc_neg", make_vec(0, 0, 1), make_vec(0, 0, -1), make_vec(0, 0, 0),
                  make_vec(1, 0, 3), make_vec(-21845.0 / 65536.0, 0, -65535.0 / 65536.0));
        set_entry(5, "zero_den", make_vec(0, 0, 1), make_vec(0, 0, 5), make_vec(2, 3, 4),
                  make_vec(1, 1, 0), make_vec(2, 3, 4));
        set_entry(6, "frac", make_vec(0, 0, 1), make_vec(0, 0, 1.5), make_vec(0, 0, 0.5),
                  make_vec(0.5, 0, 0.25), make_vec(2, 0, 1.5));
    endtask

    // called and returns 1 ns after a rising edge
    task automatic send_query(input logic [95:0] name, input p_hit_pkg::hit_query_t q,
                              input p_hit_pkg::vec3_t exp_p, input logic exp_valid);
        while (in_full) begin
            saw_full = 1'b1;
            @(posedge clock);
            #1;
        end
        in_query      = q;
        cur_name      = name;
        cur_exp       = exp_p;
        cur_exp_valid = exp_valid;
        in_wr_en      = 1'b1;
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
    endtask

    initial begin
        int i;
        int j;
        seed          = 32'h9b81c30f;
        cycles        = 0;
        tb_errors     = 0;
        saw_full      = 1'b0;
        arst_n        = 1'b0;
        in_query      = '0;
        in_wr_en      = 1'b0;
        out_rd_en     = 1'b0;
        cur_name      = '0;
        cur_exp       = '0;
        cur_exp_valid = 1'b0;
        fill_table();
        repeat (16) @(posedge clock);
        #1;
        arst_n = 1'b1;
        if (!out_empty || in_full) begin
            $display("after reset out_empty should be high and in_full low");
            tb_errors++;
        end

        // directed entries back to back
        out_rd_en = 1'b1;
        for (i = 0; i < N_DIRECTED; i++) begin
            send_query(tab_name[i], tab_query[i], tab_exp[i], 1'b1);
        end
        while (n_done < N_DIRECTED) begin
            @(posedge clock);
            #1;
        end

        // random stream against a stalled output
        fork
            begin
                for (j = 0; j < N_RANDOM; j++) begin
                    send_query("random", rand_query(), '0, 1'b0);
                end
            end
            begin
                out_rd_en = 1'b0;
                repeat (120) @(posedge clock);
                #1;
                out_rd_en = 1'b1;
            end
        join
        while (n_done < N_TOTAL) begin
            @(posedge clock);
            #1;
        end
        repeat (20) @(posedge clock);
        #1;

        if (!saw_full) begin
            $display("in_full never rose while the output was stalled");
            tb_errors++;
        end
        if (!out_empty) begin
            $display("output FIFO still holds results after all tests finished");
            tb_errors++;
        end
        $display("tests %0d of %0d, passed %0d, errors %0d",
                 n_done, N_TOTAL, n_pass, n_errors + tb_errors);
        if (n_errors == 0 && tb_errors == 0 && n_pass == N_TOTAL) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- p_hit.f
hdl/p_hit_pkg.sv
hdl/fifo_array.sv
hdl/hit_distance.sv
hdl/p_hit_point.sv
hdl/p_hit.sv
test/p_hit_checker.sv
test/p_hit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module p_hit_tb -f p_hit.f -o p_hit_sim \
    && ./obj_dir/p_hit_sim | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "sim failed" sim.log && exit 1 || exit 0
